// ==== source/bufferRam.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vread_params.svh"

module bufferRam
(
   input  wire logic                clk,
   input  wire logic                write,
   input  wire vreadCfgPkg::memAddr writeAddr,
   input  wire vreadBusPkg::busData writeData,
   input  wire logic                read,
   input  wire vreadCfgPkg::memAddr readAddr,
   output vreadBusPkg::busData      readData
);

   vreadBusPkg::busData mem [0:(1 << `VREAD_MEM_ADDR_W)-1];

   always_ff @(posedge clk)
   begin
      if (write)
         mem[writeAddr] <= writeData;
      // read data holds between strobes
      if (read)
         readData <= mem[readAddr];
   end

endmodule

`default_nettype wire

// ==== source/fetchAddrGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetchAddrGen
(
   input  wire logic                  clk,
   input  wire logic                  rst,
   input  wire logic                  start,
   input  wire vreadCfgPkg::memAddr   startAddr,
   input  wire vreadCfgPkg::iterCnt   iterations,
   input  wire vreadCfgPkg::periodCnt period,
   input  wire vreadCfgPkg::periodCnt duty,
   input  wire vreadCfgPkg::memAddr   shift,
   input  wire vreadCfgPkg::memAddr   incr,
   input  wire logic                  ready,
   output logic                       valid,
   output vreadCfgPkg::memAddr        addr,
   output logic                       done
);

   logic                  running;
   vreadCfgPkg::periodCnt perIdx;
   vreadCfgPkg::iterCnt   iterIdx;
   vreadCfgPkg::memAddr   iterBase;
   logic                  inDuty;
   logic                  step;
   logic                  lastK;
   logic                  lastI;

   assign inDuty = perIdx < duty;
   assign valid = running && inDuty;

   // gap cycles advance on their own, duty cycles wait for the writer
   assign step = running && (inDuty ? ready : 1'b1);
   assign lastK = perIdx == period - 1'b1;
   assign lastI = iterIdx == iterations - 1'b1;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         running <= 1'b0;
         done <= 1'b1;
         perIdx <= '0;
         iterIdx <= '0;
      end
      else if (start)
      begin
         running <= 1'b1;
         done <= 1'b0;
         perIdx <= '0;
         iterIdx <= '0;
      end
      else if (step)
      begin
         if (lastK)
         begin
            perIdx <= '0;
            if (lastI)
            begin
               running <= 1'b0;
               done <= 1'b1;
            end
            else
               iterIdx <= iterIdx + 1'b1;
         end
         else
            perIdx <= perIdx + 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (start)
      begin
         iterBase <= startAddr;
         addr <= startAddr;
      end
      else if (step)
      begin
         if (lastK)
         begin
            iterBase <= iterBase + shift;
            addr <= iterBase + shift;
         end
         else
            addr <= addr + incr;
      end
   end

endmodule

`default_nettype wire

// ==== source/memoryWriter.sv ====
`timescale 1ns/1ps
`default_nettype none

module memoryWriter
(
   input  wire logic                clk,
   input  wire logic                rst,
   input  wire logic                genValid,
   input  wire vreadCfgPkg::memAddr genAddr,
   input  wire logic                beatValid,
   input  wire vreadBusPkg::busData beatData,
   output logic                     genReady,
   output logic                     beatReady,
   output logic                     memWrite,
   output vreadCfgPkg::memAddr      memWriteAddr,
   output vreadBusPkg::busData      memWriteData
);

   logic accept;

   // a beat is only taken when there is an address to put it at
   assign beatReady = genValid;
   assign accept = genValid && beatValid;
   assign genReady = accept;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         memWrite <= 1'b0;
      else
         memWrite <= accept;
   end

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         memWriteAddr <= genAddr;
         memWriteData <= beatData;
      end
   end

endmodule

`default_nettype wire

// ==== source/readAddrGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module readAddrGen
(
   input  wire logic                  clk,
   input  wire logic                  rst,
   input  wire logic                  start,
   input  wire vreadCfgPkg::memAddr   startAddr,
   input  wire vreadCfgPkg::iterCnt   iterations,
   input  wire vreadCfgPkg::periodCnt period,
   input  wire vreadCfgPkg::periodCnt duty,
   input  wire vreadCfgPkg::memAddr   shift,
   input  wire vreadCfgPkg::memAddr   incr,
   input  wire vreadCfgPkg::periodCnt delay,
   input  wire vreadCfgPkg::iterCnt   iterations2,
   input  wire vreadCfgPkg::memAddr   shift2,
   output logic                       en,
   output vreadCfgPkg::memAddr        addr,
   output logic                       done
);

   logic                  active;
   vreadCfgPkg::periodCnt delayCnt;
   vreadCfgPkg::periodCnt perIdx;
   vreadCfgPkg::iterCnt   iterIdx;
   vreadCfgPkg::iterCnt   outerIdx;
   vreadCfgPkg::memAddr   outerBase;
   vreadCfgPkg::memAddr   innerBase;
   logic                  stepping;
   logic                  lastK;
   logic                  lastI;
   logic                  lastJ;
   logic                  finalStep;

   assign stepping = active && (delayCnt == '0);
   assign lastK = perIdx == period - 1'b1;
   assign lastI = iterIdx == iterations - 1'b1;
   assign lastJ = outerIdx == iterations2 - 1'b1;

   // stop on the last strobe, not on the trailing gap cycles
   assign finalStep = stepping && lastI && lastJ && (lastK || perIdx == duty - 1'b1);

   assign en = stepping && (perIdx < duty);

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         active <= 1'b0;
         done <= 1'b0;
         delayCnt <= '0;
         perIdx <= '0;
         iterIdx <= '0;
         outerIdx <= '0;
      end
      else
      begin
         done <= finalStep;
         if (start)
         begin
            active <= 1'b1;
            delayCnt <= delay;
            perIdx <= '0;
            iterIdx <= '0;
            outerIdx <= '0;
         end
         else if (finalStep)
            active <= 1'b0;
         else if (active && delayCnt != '0)
            delayCnt <= delayCnt - 1'b1;
         else if (stepping)
         begin
            if (lastK)
            begin
               perIdx <= '0;
               if (lastI)
               begin
                  iterIdx <= '0;
                  outerIdx <= outerIdx + 1'b1;
               end
               else
                  iterIdx <= iterIdx + 1'b1;
            end
            else
               perIdx <= perIdx + 1'b1;
         end
      end
   end

   // outer and inner bases move with the loops
   always_ff @(posedge clk)
   begin
      if (start)
      begin
         outerBase <= startAddr;
         innerBase <= startAddr;
         addr <= startAddr;
      end
      else if (stepping)
      begin
         if (lastK && lastI)
         begin
            outerBase <= outerBase + shift2;
            innerBase <= outerBase + shift2;
            addr <= outerBase + shift2;
         end
         else if (lastK)
         begin
            innerBase <= innerBase + shift;
            addr <= innerBase + shift;
         end
         else
            addr <= addr + incr;
      end
   end

endmodule

`default_nettype wire

// ==== source/vectorRead.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vread_params.svh"

module vectorRead
(
   input  wire logic                  clk,
   input  wire logic                  rst,
   input  wire logic                  run,
   input  wire logic                  disabled,
   input  wire logic                  busReady,
   input  wire vreadBusPkg::busData   busRData,
   input  wire logic                  busLast,
   input  wire vreadBusPkg::busAddr   extAddr,
   input  wire vreadBusPkg::burstLen  length,
   input  wire vreadCfgPkg::iterCnt   iterA,
   input  wire vreadCfgPkg::periodCnt perA,
   input  wire vreadCfgPkg::periodCnt dutyA,
   input  wire vreadCfgPkg::memAddr   shiftA,
   input  wire vreadCfgPkg::memAddr   incrA,
   input  wire logic                  pingPong,
   input  wire vreadCfgPkg::iterCnt   iterB,
   input  wire vreadCfgPkg::periodCnt perB,
   input  wire vreadCfgPkg::periodCnt dutyB,
   input  wire vreadCfgPkg::memAddr   startB,
   input  wire vreadCfgPkg::memAddr   shiftB,
   input  wire vreadCfgPkg::memAddr   incrB,
   input  wire logic                  reverseB,
   input  wire vreadCfgPkg::iterCnt   iter2B,
   input  wire vreadCfgPkg::memAddr   shift2B,
   input  wire vreadCfgPkg::periodCnt delay,
   output logic                       done,
   output logic                       busValid,
   output vreadBusPkg::busAddr        busAddr,
   output vreadBusPkg::burstLen       busLen,
   output logic                       memWrite,
   output vreadCfgPkg::memAddr        memWriteAddr,
   output vreadBusPkg::busData        memWriteData,
   output logic                       memRead,
   output vreadCfgPkg::memAddr        memReadAddr
);

   function automatic vreadCfgPkg::memAddr reverseBits(input vreadCfgPkg::memAddr word);
      vreadCfgPkg::memAddr result;
      for (int i = 0; i < `VREAD_MEM_ADDR_W; i++)
         result[i] = word[`VREAD_MEM_ADDR_W-1-i];
      return result;
   endfunction

   logic                runEff;
   logic                doneA;
   logic                doneB;
   logic                pingPongState;
   logic                genValid;
   logic                genReady;
   vreadCfgPkg::memAddr genAddr;
   logic                rdEn;
   vreadCfgPkg::memAddr rdAddr;
   logic                rdDone;
   vreadCfgPkg::memAddr startA;
   vreadCfgPkg::memAddr startBEff;

   assign runEff = run && !disabled;
   assign done = doneA && doneB;
   assign busLen = length;

   // fetch fills the half the read side is not using
   assign startA = {!pingPongState, {(`VREAD_MEM_ADDR_W-1){1'b0}}};
   assign startBEff = pingPong ? {pingPongState, startB[`VREAD_MEM_ADDR_W-2:0]} : startB;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         doneA <= 1'b1;
         doneB <= 1'b1;
         pingPongState <= 1'b0;
         busAddr <= '0;
      end
      else if (runEff)
      begin
         doneA <= 1'b0;
         doneB <= 1'b0;
         pingPongState <= pingPong ? !pingPongState : 1'b0;
         busAddr <= extAddr;
      end
      else
      begin
         if (busValid && busReady && busLast)
            doneA <= 1'b1;
         if (rdDone)
            doneB <= 1'b1;
      end
   end

   fetchAddrGen fetchGen
   (
      .clk(clk),
      .rst(rst),
      .start(runEff),
      .startAddr(startA),
      .iterations(iterA),
      .period(perA),
      .duty(dutyA),
      .shift(shiftA),
      .incr(incrA),
      .ready(genReady),
      .valid(genValid),
      .addr(genAddr),
      .done()
   );

   memoryWriter writer
   (
      .clk(clk),
      .rst(rst),
      .genValid(genValid),
      .genAddr(genAddr),
      .beatValid(busReady),
      .beatData(busRData),
      .genReady(genReady),
      .beatReady(busValid),
      .memWrite(memWrite),
      .memWriteAddr(memWriteAddr),
      .memWriteData(memWriteData)
   );

   readAddrGen readGen
   (
      .clk(clk),
      .rst(rst),
      .start(runEff),
      .startAddr(startBEff),
      .iterations(iterB),
      .period(perB),
      .duty(dutyB),
      .shift(shiftB),
      .incr(incrB),
      .delay(delay),
      .iterations2(iter2B),
      .shift2(shift2B),
      .en(rdEn),
      .addr(rdAddr),
      .done(rdDone)
   );

   assign memRead = rdEn;
   assign memReadAddr = reverseB ? reverseBits(rdAddr) : rdAddr;

endmodule

`default_nettype wire

// ==== source/vectorReadTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module vectorReadTop
(
   input  wire logic                  clk,
   input  wire logic                  rst,
   input  wire logic                  run,
   input  wire logic                  disabled,
   input  wire logic                  busReady,
   input  wire vreadBusPkg::busData   busRData,
   input  wire logic                  busLast,
   input  wire vreadBusPkg::busAddr   extAddr,
   input  wire vreadBusPkg::burstLen  length,
   input  wire vreadCfgPkg::iterCnt   iterA,
   input  wire vreadCfgPkg::periodCnt perA,
   input  wire vreadCfgPkg::periodCnt dutyA,
   input  wire vreadCfgPkg::memAddr   shiftA,
   input  wire vreadCfgPkg::memAddr   incrA,
   input  wire logic                  pingPong,
   input  wire vreadCfgPkg::iterCnt   iterB,
   input  wire vreadCfgPkg::periodCnt perB,
   input  wire vreadCfgPkg::periodCnt dutyB,
   input  wire vreadCfgPkg::memAddr   startB,
   input  wire vreadCfgPkg::memAddr   shiftB,
   input  wire vreadCfgPkg::memAddr   incrB,
   input  wire logic                  reverseB,
   input  wire vreadCfgPkg::iterCnt   iter2B,
   input  wire vreadCfgPkg::memAddr   shift2B,
   input  wire vreadCfgPkg::periodCnt delay,
   output logic                       done,
   output logic                       busValid,
   output vreadBusPkg::busAddr        busAddr,
   output vreadBusPkg::burstLen       busLen,
   output vreadBusPkg::busData        dataOut
);

   logic                memWrite;
   vreadCfgPkg::memAddr memWriteAddr;
   vreadBusPkg::busData memWriteData;
   logic                memRead;
   vreadCfgPkg::memAddr memReadAddr;

   vectorRead unit
   (
      .clk(clk),
      .rst(rst),
      .run(run),
      .disabled(disabled),
      .busReady(busReady),
      .busRData(busRData),
      .busLast(busLast),
      .extAddr(extAddr),
      .length(length),
      .iterA(iterA),
      .perA(perA),
      .dutyA(dutyA),
      .shiftA(shiftA),
      .incrA(incrA),
      .pingPong(pingPong),
      .iterB(iterB),
      .perB(perB),
      .dutyB(dutyB),
      .startB(startB),
      .shiftB(shiftB),
      .incrB(incrB),
      .reverseB(reverseB),
      .iter2B(iter2B),
      .shift2B(shift2B),
      .delay(delay),
      .done(done),
      .busValid(busValid),
      .busAddr(busAddr),
      .busLen(busLen),
      .memWrite(memWrite),
      .memWriteAddr(memWriteAddr),
      .memWriteData(memWriteData),
      .memRead(memRead),
      .memReadAddr(memReadAddr)
   );

   // dataOut follows each read strobe by one cycle
   bufferRam buffer
   (
      .clk(clk),
      .write(memWrite),
      .writeAddr(memWriteAddr),
      .writeData(memWriteData),
      .read(memRead),
      .readAddr(memReadAddr),
      .readData(dataOut)
   );

endmodule

`default_nettype wire

// ==== source/vreadBusPkg.sv ====
`default_nettype none

`include "vread_params.svh"

package vreadBusPkg;

   // byte address of a burst
   typedef logic [`VREAD_BUS_ADDR_W-1:0] busAddr;

   // one beat on the bus, also one buffer word
   typedef logic [`VREAD_DATA_W-1:0] busData;

   // beats minus one
   typedef logic [`VREAD_LEN_W-1:0] burstLen;

endpackage

`default_nettype wire

// ==== source/vreadCfgPkg.sv ====
`default_nettype none

`include "vread_params.svh"

package vreadCfgPkg;

   // word address into the buffer
   typedef logic [`VREAD_MEM_ADDR_W-1:0] memAddr;

   // period, duty and delay
   typedef logic [`VREAD_PERIOD_W-1:0] periodCnt;

   // loop iterations, same width as a buffer address
   typedef logic [`VREAD_MEM_ADDR_W-1:0] iterCnt;

endpackage

`default_nettype wire

// ==== source/vread_params.svh ====
`ifndef VREAD_PARAMS_SVH
`define VREAD_PARAMS_SVH

// width of a bus beat and of a buffer word
`define VREAD_DATA_W 32

// byte address on the external bus
`define VREAD_BUS_ADDR_W 32

// buffer word address
// top bit selects the ping-pong half
`define VREAD_MEM_ADDR_W 10

// period, duty and delay counts
`define VREAD_PERIOD_W 10

// burst length, beats minus one
`define VREAD_LEN_W 8

`endif

// ==== tb.f ====
+incdir+source
source/vreadBusPkg.sv
source/vreadCfgPkg.sv
source/fetchAddrGen.sv
source/readAddrGen.sv
source/memoryWriter.sv
source/bufferRam.sv
source/vectorRead.sv
source/vectorReadTop.sv
test/tbClock.sv
test/vectorReadTb.sv

// ==== test/tbClock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbClock
(
   output logic clk,
   output logic rst
);

   initial
   begin
      clk = 1'b0;
      forever
         #5 clk = ~clk;
   end

   // reset held for five cycles, released on a falling edge
   initial
   begin
      rst = 1'b1;
      repeat (5)
         @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
   end

endmodule

`default_nettype wire

// ==== test/vectorReadTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vread_params.svh"

module vectorReadTb;

   // worst-case cycles of one run, with and without bus stalls
   localparam int plainRun = 60;
   localparam int stalledRun = 150;
   localparam int totalCycles = 10 + 25 + 2 * plainRun + 2 * stalledRun + 5 * plainRun;

   logic                  clk;
   logic                  rst;
   logic                  run;
   logic                  disabled;
   logic                  busReady;
   vreadBusPkg::busData   busRData;
   logic                  busLast;
   vreadBusPkg::busAddr   extAddr;
   vreadBusPkg::burstLen  length;
   vreadCfgPkg::iterCnt   iterA;
   vreadCfgPkg::periodCnt perA;
   vreadCfgPkg::periodCnt dutyA;
   vreadCfgPkg::memAddr   shiftA;
   vreadCfgPkg::memAddr   incrA;
   logic                  pingPong;
   vreadCfgPkg::iterCnt   iterB;
   vreadCfgPkg::periodCnt perB;
   vreadCfgPkg::periodCnt dutyB;
   vreadCfgPkg::memAddr   startB;
   vreadCfgPkg::memAddr   shiftB;
   vreadCfgPkg::memAddr   incrB;
   logic                  reverseB;
   vreadCfgPkg::iterCnt   iter2B;
   vreadCfgPkg::memAddr   shift2B;
   vreadCfgPkg::periodCnt delay;
   logic                  done;
   logic                  busValid;
   vreadBusPkg::busAddr   busAddr;
   vreadBusPkg::burstLen  busLen;
   vreadBusPkg::busData   dataOut;

   vreadBusPkg::busData   modelMem [0:(1 << `VREAD_MEM_ADDR_W)-1];
   vreadCfgPkg::memAddr   readSeq[$];
   logic                  ppState;
   int                    beatIdx;
   int unsigned           seedValue;
   int                    flagErrors;
   int                    dataErrors;
   int                    addrErrors;
   int                    lenErrors;
   int                    otherErrors;

   tbClock clockGen
   (
      .clk(clk),
      .rst(rst)
   );

   vectorReadTop i_dut
   (
      .clk(clk), .rst(rst), .run(run), .disabled(disabled),
      .busReady(busReady), .busRData(busRData), .busLast(busLast),
      .extAddr(extAddr), .length(length),
      .iterA(iterA), .perA(perA), .dutyA(dutyA), .shiftA(shiftA), .incrA(incrA),
      .pingPong(pingPong),
      .iterB(iterB), .perB(perB), .dutyB(dutyB), .startB(startB),
      .shiftB(shiftB), .incrB(incrB), .reverseB(reverseB),
      .iter2B(iter2B), .shift2B(shift2B), .delay(delay),
      .done(done), .busValid(busValid), .busAddr(busAddr), .busLen(busLen),
      .dataOut(dataOut)
   );

   task automatic checkFlag(input string name, input logic expected, input logic actual);
      if (actual !== expected)
      begin
         $display("ERR %s: expected %b, actual %b", name, expected, actual);
         flagErrors++;
      end
   endtask

   task automatic checkData(input string name, input vreadBusPkg::busData expected,
                            input vreadBusPkg::busData actual);
      if (actual !== expected)
      begin
         $display("ERR %s: expected %h, actual %h", name, expected, actual);
         dataErrors++;
      end
   endtask

   task automatic checkAddr(input string name, input vreadBusPkg::busAddr expected,
                            input vreadBusPkg::busAddr actual);
      if (actual !== expected)
      begin
         $display("ERR %s: expected %h, actual %h", name, expected, actual);
         addrErrors++;
      end
   endtask

   task automatic checkLen(input string name, input vreadBusPkg::burstLen expected,
                           input vreadBusPkg::burstLen actual);
      if (actual !== expected)
      begin
         $display("ERR %s: expected %0d, actual %0d", name, expected, actual);
         lenErrors++;
      end
   endtask

   function automatic vreadCfgPkg::memAddr mirrorAddr(input vreadCfgPkg::memAddr a);
      vreadCfgPkg::memAddr r;
      r = '0;
      for (int b = 0; b < `VREAD_MEM_ADDR_W; b++)
         r = {r[`VREAD_MEM_ADDR_W-2:0], a[b]};
      return r;
   endfunction

   // 16-word fetch and read with unit increment
   task automatic linearConfig();
      length = 8'd15;
      iterA = 10'd1;
      perA = 10'd16;
      dutyA = 10'd16;
      shiftA = '0;
      incrA = 10'd1;
      pingPong = 1'b0;
      iterB = 10'd1;
      perB = 10'd16;
      dutyB = 10'd16;
      startB = 10'd512;
      shiftB = '0;
      incrB = 10'd1;
      reverseB = 1'b0;
      iter2B = 10'd1;
      shift2B = '0;
      delay = '0;
   endtask

   // beat value is the burst address plus the beat index
   task automatic driveBus(input bit stall);
      busReady = stall ? (($urandom % 4) != 0) : 1'b1;
      busRData = busAddr + beatIdx;
      busLast = beatIdx == busLen;
      if (busValid && busReady)
         beatIdx++;
   endtask

   task automatic buildReadSeq(input vreadCfgPkg::memAddr base);
      vreadCfgPkg::memAddr a;
      readSeq.delete();
      for (int j = 0; j < iter2B; j++)
         for (int i = 0; i < iterB; i++)
            for (int k = 0; k < perB; k++)
               if (k < dutyB)
               begin
                  a = base + j * shift2B + i * shiftB + k * incrB;
                  readSeq.push_back(a);
               end
   endtask

   task automatic storeFetch(input vreadCfgPkg::memAddr base);
      vreadCfgPkg::memAddr a;
      int beat;
      beat = 0;
      for (int i = 0; i < iterA; i++)
         for (int k = 0; k < perA; k++)
            if (k < dutyA)
            begin
               a = base + i * shiftA + k * incrA;
               modelMem[a] = extAddr + beat;
               beat++;
            end
   endtask

   // runs once and collects dataOut one cycle after each read strobe
   task automatic runOnce(input string name, input bit check, input bit stall);
      vreadCfgPkg::memAddr fetchStart;
      vreadCfgPkg::memAddr readStart;
      vreadBusPkg::busData got[$];
      vreadBusPkg::busData want;
      logic pending;
      logic finished;
      fetchStart = {!ppState, {(`VREAD_MEM_ADDR_W-1){1'b0}}};
      readStart = pingPong ? {ppState, startB[`VREAD_MEM_ADDR_W-2:0]} : startB;
      buildReadSeq(readStart);
      @(negedge clk);
      run = 1'b1;
      beatIdx = 0;
      driveBus(stall);
      @(negedge clk);
      run = 1'b0;
      checkFlag({name, " busy"}, 1'b0, done);
      pending = 1'b0;
      finished = 1'b0;
      while (!finished)
      begin
         if (pending)
            got.push_back(dataOut);
         pending = i_dut.memRead;
         driveBus(stall);
         finished = done;
         if (!finished)
            @(negedge clk);
      end
      if (check)
      begin
         if (got.size() != readSeq.size())
         begin
            $display("%s: dataOut gave %0d words where %0d were expected",
                     name, got.size(), readSeq.size());
            otherErrors++;
         end
         else
            for (int n = 0; n < got.size(); n++)
            begin
               want = modelMem[reverseB ? mirrorAddr(readSeq[n]) : readSeq[n]];
               checkData($sformatf("%s word %0d", name, n), want, got[n]);
            end
      end
      storeFetch(fetchStart);
      ppState = pingPong ? !ppState : 1'b0;
   endtask

   task automatic resetAndDisabled();
      @(negedge clk);
      checkFlag("reset done", 1'b1, done);
      checkFlag("reset busValid", 1'b0, busValid);
      busReady = 1'b1;
      disabled = 1'b1;
      run = 1'b1;
      @(negedge clk);
      run = 1'b0;
      repeat (20)
      begin
         @(negedge clk);
         checkFlag("disabled busValid", 1'b0, busValid);
         checkFlag("disabled memRead", 1'b0, i_dut.memRead);
         checkFlag("disabled done", 1'b1, done);
      end
      disabled = 1'b0;
   endtask

   task automatic linearTransfer();
      linearConfig();
      extAddr = 32'h1000_0000;
      runOnce("linear prime", 1'b0, 1'b0);
      checkAddr("linear busAddr", extAddr, busAddr);
      checkLen("linear busLen", length, busLen);
      runOnce("linear", 1'b1, 1'b0);
   endtask

   task automatic stalledTransfer();
      extAddr = 32'h2000_0400;
      runOnce("stall prime", 1'b0, 1'b1);
      runOnce("stall", 1'b1, 1'b1);
   endtask

   task automatic twoLevelRead();
      perB = 10'd4;
      dutyB = 10'd3;
      iterB = 10'd2;
      shiftB = 10'd4;
      iter2B = 10'd2;
      shift2B = 10'd8;
      delay = 10'd3;
      runOnce("two-level", 1'b1, 1'b0);
   endtask

   // addresses 1 + 64m land in the upper half once reversed
   task automatic reversedRead();
      linearConfig();
      startB = 10'd1;
      incrB = 10'd64;
      reverseB = 1'b1;
      runOnce("reverse", 1'b1, 1'b0);
   endtask

   task automatic pingPongRuns();
      linearConfig();
      pingPong = 1'b1;
      startB = '0;
      extAddr = 32'h3000_0000;
      runOnce("ping-pong 1", 1'b0, 1'b0);
      extAddr = 32'h3100_0000;
      runOnce("ping-pong 2", 1'b1, 1'b0);
      extAddr = 32'h3200_0000;
      runOnce("ping-pong 3", 1'b1, 1'b0);
      pingPong = 1'b0;
   endtask

   initial
   begin
      #(4 * totalCycles * 10);
      $display("timeout: tests did not finish within %0d cycles", 4 * totalCycles);
      $display("TEST FAILED");
      $finish;
   end

   initial
   begin
      seedValue = $urandom(32'hefba);
      flagErrors = 0;
      dataErrors = 0;
      addrErrors = 0;
      lenErrors = 0;
      otherErrors = 0;
      ppState = 1'b0;
      beatIdx = 0;
      run = 1'b0;
      disabled = 1'b0;
      busReady = 1'b0;
      busRData = '0;
      busLast = 1'b0;
      extAddr = '0;
      linearConfig();
      wait (rst === 1'b0);
      resetAndDisabled();
      linearTransfer();
      stalledTransfer();
      twoLevelRead();
      reversedRead();
      pingPongRuns();
      $display("errors: flag %0d, data %0d, addr %0d, len %0d, other %0d",
               flagErrors, dataErrors, addrErrors, lenErrors, otherErrors);
      if (flagErrors + dataErrors + addrErrors + lenErrors + otherErrors == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire
